// File: compile.f
hw/video_pkg.sv
hw/video_if.sv
hw/video_timing.sv
hw/video_regs.sv
hw/video_playfield.sv
hw/video_gen.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_video_gen.sv

// File: dv/tb_checker.sv
// testbench checker for the raster video generator
// mirrors register writes and predicts pixels, sync shape, interrupts and read-back
`default_nettype none

module tb_checker
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_en_i,
    input  wire logic [3:0] reg_num_i,
    input  wire word_t      reg_wr_data_i,
    input  wire word_t      reg_rd_data_i,
    input  wire logic [3:0] intr_status_i,
    input  wire logic [3:0] intr_signal_i,
    input  wire color_t     color_index_i,
    input  wire logic       hsync_i,
    input  wire logic       vsync_i,
    input  wire logic       dv_de_i,
    output      int         errors_o,
    output      int         checks_o
);

    color_t     border, colorbase;
    logic       blank;
    hcount_t    vid_left, vid_right;
    addr_t      start_addr;
    word_t      line_len;
    logic [3:0] exp_intr;           // expected on the next edge
    word_t      exp_rd;
    logic       rd_valid;
    hcount_t    x;                  // position counted from dv_de runs
    vcount_t    y;
    int         de_count, frame_cycles, hs_run;
    logic       seen_frame;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    task automatic compare(input string name, input word_t exp, input word_t got);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    function automatic word_t model_word(input addr_t a);
        return (a * 16'h9e37) ^ 16'h5a5a;
    endfunction

    function automatic color_t expected_pixel(input hcount_t col, input vcount_t row);
        addr_t a;
        word_t w;
        if (blank || col < vid_left || col >= vid_right) begin
            return border;
        end
        a = start_addr + addr_t'(row) * line_len + addr_t'(col >> 1);
        w = model_word(a);
        return (col[0] ? w[7:0] : w[15:8]) ^ colorbase;   // even pixel in the high byte
    endfunction

    always @(posedge clk) begin
        logic vs_act;
        logic hs_act;
        if (reset_i) begin
            border     = BORDER_RESET;
            colorbase  = '0;
            blank      = PA_BLANK_RESET;
            vid_left   = '0;
            vid_right  = hcount_t'(H_VISIBLE);
            start_addr = '0;
            line_len   = LINE_LEN_RESET;
            exp_intr   = '0;
            rd_valid   = 1'b0;
            x          = '0;
            y          = '0;
            de_count   = 0;
            frame_cycles = 0;
            hs_run     = 0;
            seen_frame = 1'b0;
            vs_act     = 1'b0;
        end else begin
            hs_act = (hsync_i == H_SYNC_POLARITY);
            compare("intr_signal_o", 16'(exp_intr), 16'(intr_signal_i));
            if (rd_valid) begin
                compare("vgen_reg_data_o", exp_rd, reg_rd_data_i);
            end
            exp_intr = '0;
            // a new frame begins where vsync turns active
            if ((vsync_i == V_SYNC_POLARITY) && !vs_act) begin
                if (seen_frame) begin
                    compare("vsync_o period", 16'(H_TOTAL * V_TOTAL), 16'(frame_cycles));
                    compare("dv_de_o cycles per frame", 16'(H_VISIBLE * V_VISIBLE),
                            16'(de_count));
                end
                seen_frame   = 1'b1;
                frame_cycles = 0;
                de_count     = 0;
                x            = '0;
                y            = '0;
            end
            vs_act = (vsync_i == V_SYNC_POLARITY);
            if (hs_act) begin
                hs_run++;
            end else if (hs_run != 0) begin
                compare("hsync_o pulse length", 16'(H_SYNC_PULSE), 16'(hs_run));
                hs_run = 0;
            end
            if (dv_de_i) begin
                compare("color_index_o", 16'(expected_pixel(x, y)), 16'(color_index_i));
                if (x == hcount_t'(H_VISIBLE - 1) && y == vcount_t'(V_VISIBLE - 1)) begin
                    exp_intr[3] = 1'b1;                     // end of the visible frame
                end
                de_count++;
                if (x == hcount_t'(H_VISIBLE - 1)) begin
                    x = '0;
                    y = y + 1'b1;
                end else begin
                    x = x + 1'b1;
                end
            end
            // read-back seen on the next edge, from the values before this write
            rd_valid = 1'b1;
            case (reg_num_i)
                VID_CTRL:     exp_rd = {border, 4'h0, intr_status_i};
                VID_LEFT:     exp_rd = 16'(vid_left);
                VID_RIGHT:    exp_rd = 16'(vid_right);
                SCANLINE:     rd_valid = 1'b0;              // depends on the beam
                VID_HSIZE:    exp_rd = 16'(H_VISIBLE);
                VID_VSIZE:    exp_rd = 16'(V_VISIBLE);
                PA_GFX_CTRL:  exp_rd = {colorbase, blank, 7'h00};
                PA_DISP_ADDR: exp_rd = start_addr;
                PA_LINE_LEN:  exp_rd = line_len;
                default:      exp_rd = 16'h0000;
            endcase
            if (reg_wr_en_i) begin
                case (reg_num_i)
                    VID_CTRL: begin
                        border   = reg_wr_data_i[15:8];
                        exp_intr = exp_intr | reg_wr_data_i[3:0];
                    end
                    VID_LEFT:     vid_left   = reg_wr_data_i[4:0];
                    VID_RIGHT:    vid_right  = reg_wr_data_i[4:0];
                    PA_GFX_CTRL: begin
                        colorbase = reg_wr_data_i[15:8];
                        blank     = reg_wr_data_i[7];
                    end
                    PA_DISP_ADDR: start_addr = reg_wr_data_i;
                    PA_LINE_LEN:  line_len   = reg_wr_data_i;
                    default: begin
                    end
                endcase
            end
            frame_cycles++;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
// testbench clock and reset
// clock period of 4, reset held high for the first 4 rising edges
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk     = 1'b0;
        reset_o = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset_o = 1'b0;      // released just after the edge like other inputs
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: dv/tb_video_gen.sv
// testbench top for the raster video generator
// applies a table of register writes, one per frame start, with a VRAM model
`default_nettype none

module tb_video_gen
    import video_pkg::*;
();

    localparam int ROWS   = 14;
    localparam int MARGIN = 500;                // cycles

    typedef struct packed {
        logic [3:0] num;
        word_t      data;
        word_t      rnd_mask;                   // bits replaced by random values
        logic [3:0] frames;
    } stim_row_t;

    stim_row_t stim [ROWS] = '{
        '{PA_GFX_CTRL,  16'h0080, 16'h0000, 4'd1},     // blanked, border only
        '{VID_CTRL,     16'h3105, 16'h0000, 4'd1},
        '{PA_GFX_CTRL,  16'h0000, 16'hff00, 4'd2},     // bitmap on, random colorbase
        '{PA_DISP_ADDR, 16'h0000, 16'hffff, 4'd1},
        '{PA_LINE_LEN,  16'h0000, 16'h003f, 4'd1},
        '{VID_LEFT,     16'h0003, 16'h0000, 4'd1},
        '{VID_RIGHT,    16'h000d, 16'h0000, 4'd1},
        '{PA_GFX_CTRL,  16'h0000, 16'hff00, 4'd1},
        '{VID_CTRL,     16'hc20a, 16'h0000, 4'd1},
        '{PA_DISP_ADDR, 16'h0000, 16'hffff, 4'd1},
        '{VID_LEFT,     16'h0000, 16'h0000, 4'd1},
        '{VID_RIGHT,    16'h0010, 16'h0000, 4'd1},
        '{PA_LINE_LEN,  16'h0000, 16'hffff, 4'd2},
        '{4'h7,         16'hffff, 16'h0000, 4'd1}      // unused number, no effect
    };

    logic        clk, reset;
    logic        reg_wr_en;
    logic [3:0]  reg_num;
    word_t       reg_wr_data, reg_rd_data;
    logic [3:0]  intr_status, intr_signal;
    logic        vram_sel;
    addr_t       vram_addr;
    word_t       vram_data;
    color_t      color_index;
    logic        hsync, vsync, dv_de;
    int          errors, checks;
    int          cycles, cycle_limit;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // odd multiplier keeps the pattern one to one over the whole address
    function automatic word_t vram_word(input addr_t a);
        return (a * 16'h9e37) ^ 16'h5a5a;
    endfunction

    tb_clock u_clock (
        .clk     (clk),
        .reset_o (reset)
    );

    video_gen UUT (
        .clk              (clk),
        .reset_i          (reset),
        .vgen_reg_wr_en_i (reg_wr_en),
        .vgen_reg_num_i   (reg_num),
        .vgen_reg_data_i  (reg_wr_data),
        .vgen_reg_data_o  (reg_rd_data),
        .intr_status_i    (intr_status),
        .intr_signal_o    (intr_signal),
        .vram_sel_o       (vram_sel),
        .vram_addr_o      (vram_addr),
        .vram_data_i      (vram_data),
        .color_index_o    (color_index),
        .hsync_o          (hsync),
        .vsync_o          (vsync),
        .dv_de_o          (dv_de)
    );

    tb_checker u_checker (
        .clk           (clk),
        .reset_i       (reset),
        .reg_wr_en_i   (reg_wr_en),
        .reg_num_i     (reg_num),
        .reg_wr_data_i (reg_wr_data),
        .reg_rd_data_i (reg_rd_data),
        .intr_status_i (intr_status),
        .intr_signal_i (intr_signal),
        .color_index_i (color_index),
        .hsync_i       (hsync),
        .vsync_i       (vsync),
        .dv_de_i       (dv_de),
        .errors_o      (errors),
        .checks_o      (checks)
    );

    // VRAM answers one cycle after the select
    always @(posedge clk) begin
        if (vram_sel) begin
            vram_data <= vram_word(vram_addr);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the frames did not complete", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // returns just after vsync turns active
    task automatic wait_frame_start();
        logic was_active;
        do begin
            was_active = (vsync == V_SYNC_POLARITY);
            next_cycle();
        end while (!((vsync == V_SYNC_POLARITY) && !was_active));
    endtask

    task automatic write_reg(input logic [3:0] num, input word_t data);
        reg_num     = num;
        reg_wr_data = data;
        reg_wr_en   = 1'b1;
        next_cycle();
        reg_wr_en   = 1'b0;
    endtask

    task automatic sweep_readback();
        for (int n = 0; n < 16; n++) begin
            reg_num = 4'(n);
            next_cycle();
        end
        reg_num = VID_HSIZE;
    endtask

    initial begin
        word_t data;
        int    total_frames;
        reg_wr_en   = 1'b0;
        reg_num     = VID_HSIZE;
        reg_wr_data = '0;
        intr_status = '0;
        vram_data   = '0;
        cycles      = 0;
        rng         = 32'hb502_d43d;
        total_frames = 2;                       // partial frame after reset plus slack
        foreach (stim[r]) begin
            total_frames += int'(stim[r].frames);
        end
        cycle_limit = total_frames * H_TOTAL * V_TOTAL + MARGIN;
        wait (!reset);
        wait_frame_start();
        for (int r = 0; r < ROWS; r++) begin
            rng  = xorshift32(rng);
            data = (stim[r].data & ~stim[r].rnd_mask) | (rng[15:0] & stim[r].rnd_mask);
            intr_status = rng[19:16];           // status bits read back through VID_CTRL
            write_reg(stim[r].num, data);       // lands in vertical blanking
            sweep_readback();
            repeat (stim[r].frames) wait_frame_start();
            $display("row %0d done: reg %0d data %04h, %0d frames, %0d errors so far",
                     r, stim[r].num, data, stim[r].frames, errors);
        end
        next_cycle();
        $display("%0d rows, %0d checks, %0d errors", ROWS, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/video_gen.sv
// raster video generator top level
// joins the timing generator, configuration registers and bitmap playfield
`default_nettype none

module video_gen
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       vgen_reg_wr_en_i,     // register write strobe
    input  wire logic [3:0] vgen_reg_num_i,
    input  wire word_t      vgen_reg_data_i,
    output      word_t      vgen_reg_data_o,      // valid one cycle after the number
    input  wire logic [3:0] intr_status_i,
    output      logic [3:0] intr_signal_o,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,
    output      color_t     color_index_o,
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o
);

    vcount_t    v_count;
    logic       h_visible;
    logic       v_visible;
    logic       last_visible;

    beam_if     beam();
    pf_cfg_if   cfg();

    video_timing u_timing (
        .clk            (clk),
        .reset_i        (reset_i),
        .h_count_o      (),                 // playfield takes h_count from the beam
        .v_count_o      (v_count),
        .h_visible_o    (h_visible),
        .v_visible_o    (v_visible),
        .last_visible_o (last_visible),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .beam           (beam.timing_mp)
    );

    video_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_en_i    (vgen_reg_wr_en_i),
        .reg_num_i      (xr_reg_t'(vgen_reg_num_i)),
        .reg_data_i     (vgen_reg_data_i),
        .reg_data_o     (vgen_reg_data_o),
        .v_count_i      (v_count),
        .h_visible_i    (h_visible),
        .v_visible_i    (v_visible),
        .last_visible_i (last_visible),
        .intr_status_i  (intr_status_i),
        .intr_signal_o  (intr_signal_o),
        .cfg            (cfg.regs_mp)
    );

    video_playfield u_playfield (
        .clk            (clk),
        .reset_i        (reset_i),
        .beam           (beam.pf_mp),
        .cfg            (cfg.pf_mp),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_i    (vram_data_i),
        .color_index_o  (color_index_o)
    );

endmodule

`default_nettype wire

// File: hw/video_if.sv
// video generator interfaces
// beam position events and playfield configuration
`default_nettype none

interface beam_if
    import video_pkg::*;
();
    hcount_t    h_count;        // current horizontal count
    logic       visible;        // both h and v visible on the next cycle
    logic       line_start;     // first cycle of a visible line
    logic       frame_start;    // first cycle of line 0

    modport timing_mp (
        output h_count,
        output visible,
        output line_start,
        output frame_start
    );

    modport pf_mp (
        input  h_count,
        input  visible,
        input  line_start,
        input  frame_start
    );
endinterface

interface pf_cfg_if
    import video_pkg::*;
();
    logic       blank;          // show border only
    color_t     colorbase;      // XOR'd with each pixel
    addr_t      start_addr;     // first word of the frame
    word_t      line_len;       // words added per line
    color_t     border_color;
    hcount_t    vid_left;       // inclusive
    hcount_t    vid_right;      // exclusive

    modport regs_mp (
        output blank, colorbase, start_addr, line_len, border_color, vid_left, vid_right
    );

    modport pf_mp (
        input  blank, colorbase, start_addr, line_len, border_color, vid_left, vid_right
    );
endinterface

`default_nettype wire

// File: hw/video_pkg.sv
// video generator package
// timing constants, register numbers and shared types for the raster generator
`default_nettype none

package video_pkg;

    // horizontal timing in pixels, offscreen pixels come first on a line
    localparam int H_VISIBLE        = 16;
    localparam int H_FRONT_PORCH    = 2;
    localparam int H_SYNC_PULSE     = 3;
    localparam int H_BACK_PORCH     = 3;
    localparam int H_OFFSCREEN      = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int H_TOTAL          = 24;

    // vertical timing in lines, visible lines come first
    localparam int V_VISIBLE        = 6;
    localparam int V_FRONT_PORCH    = 1;
    localparam int V_SYNC_PULSE     = 2;
    localparam int V_BACK_PORCH     = 1;
    localparam int V_TOTAL          = 10;

    localparam logic H_SYNC_POLARITY = 1'b0;   // level while in SYNC
    localparam logic V_SYNC_POLARITY = 1'b0;

    typedef logic [4:0]  hcount_t;
    typedef logic [3:0]  vcount_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;               // VRAM word address
    typedef logic [7:0]  color_t;              // palette index

    typedef enum logic [1:0] {
        PRE_SYNC    = 2'b00,
        SYNC        = 2'b01,
        POST_SYNC   = 2'b10,
        VISIBLE     = 2'b11
    } video_state_t;

    typedef enum logic [3:0] {
        VID_CTRL        = 4'h0,
        VID_LEFT        = 4'h1,
        VID_RIGHT       = 4'h2,
        SCANLINE        = 4'h3,                // read only
        VID_HSIZE       = 4'h4,
        VID_VSIZE       = 4'h5,
        PA_GFX_CTRL     = 4'h8,
        PA_DISP_ADDR    = 4'h9,
        PA_LINE_LEN     = 4'hA
    } xr_reg_t;

    // fetch runs two pixels ahead of the display
    localparam hcount_t PF_FETCH_FIRST = hcount_t'(H_OFFSCREEN - 2);
    localparam hcount_t PF_FETCH_END   = hcount_t'(H_OFFSCREEN - 2 + H_VISIBLE);
    localparam hcount_t PF_COL_OFFSET  = hcount_t'(H_OFFSCREEN - 1);

    localparam color_t BORDER_RESET    = 8'h08;   // dark grey
    localparam word_t  LINE_LEN_RESET  = 16'd8;
    localparam logic   PA_BLANK_RESET  = 1'b1;

endpackage

`default_nettype wire

// File: hw/video_playfield.sv
// bitmap playfield
// fetches one VRAM word per pixel pair and applies window, border and colorbase
`default_nettype none

module video_playfield
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    beam_if.pf_mp           beam,
    pf_cfg_if.pf_mp         cfg,
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    input  wire word_t      vram_data_i,
    output      color_t     color_index_o
);

    addr_t      line_addr;          // first word of the current line
    addr_t      fetch_addr;
    addr_t      next_line_addr;
    logic       line_active;        // current line is a visible one
    logic       rd_q;               // vram data valid this cycle
    color_t     low_byte;           // odd pixel of the last word
    hcount_t    fetch_pix;
    hcount_t    col;
    color_t     pixel;
    logic       in_window;
    color_t     color_next;

    // fetch stage, two cycles ahead of the display column
    always_comb begin
        fetch_pix      = beam.h_count - PF_FETCH_FIRST;
        vram_sel_o     = line_active && (beam.h_count >= PF_FETCH_FIRST) &&
                         (beam.h_count < PF_FETCH_END) && !fetch_pix[0];
        next_line_addr = beam.frame_start ? cfg.start_addr : line_addr + cfg.line_len;
    end

    assign vram_addr_o = fetch_addr;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_active <= 1'b0;
            rd_q        <= 1'b0;
        end else begin
            if (beam.h_count == '0) begin
                line_active <= beam.line_start;
            end
            rd_q <= vram_sel_o;
        end
    end

    always_ff @(posedge clk) begin
        if (beam.line_start) begin
            line_addr  <= next_line_addr;
            fetch_addr <= next_line_addr;
        end else if (vram_sel_o) begin
            fetch_addr <= fetch_addr + 1'b1;
        end
        if (rd_q) begin
            low_byte <= vram_data_i[7:0];
        end
        color_index_o <= color_next;
    end

    // data stage, col is the column shown on the next cycle
    always_comb begin
        col        = beam.h_count - PF_COL_OFFSET;
        pixel      = rd_q ? vram_data_i[15:8] : low_byte;     // high byte is the even pixel
        in_window  = (col >= cfg.vid_left) && (col < cfg.vid_right);
        if (!beam.visible || cfg.blank || !in_window) begin
            color_next = cfg.border_color;
        end else begin
            color_next = pixel ^ cfg.colorbase;
        end
    end

endmodule

`default_nettype wire

// File: hw/video_regs.sv
// video configuration registers
// write decode, registered read-back and interrupt pulses
`default_nettype none

module video_regs
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_en_i,
    input  wire xr_reg_t    reg_num_i,
    input  wire word_t      reg_data_i,
    output      word_t      reg_data_o,
    input  wire vcount_t    v_count_i,
    input  wire logic       h_visible_i,
    input  wire logic       v_visible_i,
    input  wire logic       last_visible_i,
    input  wire logic [3:0] intr_status_i,
    output      logic [3:0] intr_signal_o,
    pf_cfg_if.regs_mp       cfg
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o       <= 4'b0;
            cfg.border_color    <= BORDER_RESET;
            cfg.vid_left        <= '0;
            cfg.vid_right       <= hcount_t'(H_VISIBLE);   // full width
            cfg.blank           <= PA_BLANK_RESET;
            cfg.colorbase       <= '0;
            cfg.start_addr      <= '0;
            cfg.line_len        <= LINE_LEN_RESET;
        end else begin
            intr_signal_o <= 4'b0;                          // pulses last one cycle
            if (reg_wr_en_i) begin
                case (reg_num_i)
                    VID_CTRL: begin
                        cfg.border_color <= reg_data_i[15:8];
                        intr_signal_o    <= reg_data_i[3:0];   // software interrupts
                    end
                    VID_LEFT:     cfg.vid_left   <= reg_data_i[$bits(hcount_t)-1:0];
                    VID_RIGHT:    cfg.vid_right  <= reg_data_i[$bits(hcount_t)-1:0];
                    PA_GFX_CTRL: begin
                        cfg.colorbase <= reg_data_i[15:8];
                        cfg.blank     <= reg_data_i[7];
                    end
                    PA_DISP_ADDR: cfg.start_addr <= reg_data_i;
                    PA_LINE_LEN:  cfg.line_len   <= reg_data_i;
                    default: begin
                    end
                endcase
            end
            // end of visible frame
            if (last_visible_i) begin
                intr_signal_o[3] <= 1'b1;
            end
        end
    end

    // read-back, one cycle behind the register number
    always_ff @(posedge clk) begin
        case (reg_num_i)
            VID_CTRL:     reg_data_o <= {cfg.border_color, 4'b0, intr_status_i};
            VID_LEFT:     reg_data_o <= 16'(cfg.vid_left);
            VID_RIGHT:    reg_data_o <= 16'(cfg.vid_right);
            SCANLINE:     reg_data_o <= {~v_visible_i, ~h_visible_i, 14'(v_count_i)};
            VID_HSIZE:    reg_data_o <= 16'(H_VISIBLE);
            VID_VSIZE:    reg_data_o <= 16'(V_VISIBLE);
            PA_GFX_CTRL:  reg_data_o <= {cfg.colorbase, cfg.blank, 7'b0};
            PA_DISP_ADDR: reg_data_o <= cfg.start_addr;
            PA_LINE_LEN:  reg_data_o <= cfg.line_len;
            default:      reg_data_o <= 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/video_timing.sv
// video timing generator
// horizontal and vertical counters with four-state sync machines
`default_nettype none

module video_timing
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    output      hcount_t    h_count_o,
    output      vcount_t    v_count_o,
    output      logic       h_visible_o,
    output      logic       v_visible_o,
    output      logic       last_visible_o,    // last visible pixel of the frame
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o,
    beam_if.timing_mp       beam
);

    video_state_t   h_state, h_state_next;
    video_state_t   v_state, v_state_next;
    hcount_t        h_count, h_limit;
    vcount_t        v_count, v_limit;
    logic           h_line_last;

    // count at which each state ends
    always_comb begin
        case (h_state)
            PRE_SYNC:   h_limit = hcount_t'(H_FRONT_PORCH - 1);
            SYNC:       h_limit = hcount_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            POST_SYNC:  h_limit = hcount_t'(H_OFFSCREEN - 1);
            default:    h_limit = hcount_t'(H_TOTAL - 1);       // visible
        endcase
        case (v_state)
            PRE_SYNC:   v_limit = vcount_t'(V_VISIBLE + V_FRONT_PORCH - 1);
            SYNC:       v_limit = vcount_t'(V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            POST_SYNC:  v_limit = vcount_t'(V_TOTAL - 1);
            default:    v_limit = vcount_t'(V_VISIBLE - 1);
        endcase
    end

    always_comb begin
        h_line_last  = (h_state == VISIBLE) && (h_count == h_limit);
        h_state_next = (h_count == h_limit) ? video_state_t'(h_state + 2'd1) : h_state;
        v_state_next = (h_line_last && v_count == v_limit) ?
                       video_state_t'(v_state + 2'd1) : v_state;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;
            v_state <= VISIBLE;                 // frame starts on line 0
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~H_SYNC_POLARITY;
            vsync_o <= ~V_SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            if (h_line_last) begin
                h_count <= '0;
                v_count <= (v_count == vcount_t'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
            hsync_o <= (h_state_next == SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= (v_state_next == SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o <= (h_state_next == VISIBLE) && (v_state_next == VISIBLE);
        end
    end

    assign h_count_o        = h_count;
    assign v_count_o        = v_count;
    assign h_visible_o      = (h_state == VISIBLE);
    assign v_visible_o      = (v_state == VISIBLE);
    assign last_visible_o   = h_line_last && (v_state == VISIBLE) && (v_state_next == PRE_SYNC);

    assign beam.h_count     = h_count;
    assign beam.visible     = (h_state_next == VISIBLE) && (v_state_next == VISIBLE);
    assign beam.line_start  = (h_count == '0) && (v_state == VISIBLE);
    assign beam.frame_start = (h_count == '0) && (v_state == VISIBLE) && (v_count == '0);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the video generator testbench with Verilator
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_video_gen \
    && ./obj_dir/Vtb_video_gen > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
